// File: hdl/fetch_pkg.sv
/* widths, opcode constants, instruction union,
   lane and fetch packet structs for the fetch front end */
`default_nettype none

package fetch_pkg;

  localparam int xlen = 64;                  // pc and address width
  localparam int ilen = 32;                  // one instruction

  localparam logic [5:0] op_br_lo      = 6'h30; // branch opcode range
  localparam logic [5:0] op_br_hi      = 6'h3f;
  localparam logic [5:0] op_operate_lo = 6'h10; // integer operate group
  localparam logic [5:0] op_operate_hi = 6'h13;
  localparam logic [4:0] zero_reg      = 5'd31; // r31 reads as zero, so no dest

  //////////////////////////////
  // instruction formats

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;                         // link reg for bsr/br
    logic [20:0] disp;                       // signed word displacement
  } br_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] func;                       // sbz/lit flag and function code
    logic [4:0]  rc;                         // destination
  } opr_fmt_t;

  typedef union packed {
    br_fmt_t  br;
    opr_fmt_t opr;
  } inst_t;

  //////////////////////////////
  // lanes and packet

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] npc;                    // pc of this instruction + 4
    inst_t           ir;
  } raw_lane_t;

  typedef struct packed {
    raw_lane_t       raw;
    logic            is_branch;
    logic [xlen-1:0] branch_target;
    logic [4:0]      dest_reg;               // zero_reg when none
  } lane_t;

  typedef struct packed {
    lane_t lane_1;                           // older instruction
    lane_t lane_2;
  } fetch_pkt_t;

endpackage

`default_nettype wire

// File: hdl/imem.sv
/* word-wide instruction memory,
   sync load port and async read */
`timescale 1ns/1ps
`default_nettype none

module imem
#(
  parameter int imem_addr_bits = 8
)
(
  input  logic                      clock,
  input  logic                      load_en,   // write strobe from the testbench
  input  logic [imem_addr_bits-1:0] load_addr,
  input  logic [63:0]               load_data,
  input  logic [imem_addr_bits-1:0] read_addr, // word index from fetch
  output logic [63:0]               read_data
);

  localparam int depth = 2 ** imem_addr_bits;

  logic [63:0] mem [depth];                  // contents only what was loaded

  // load port
  always_ff @(posedge clock)
  begin
    if (load_en)
      mem[load_addr] <= load_data;
  end

  // read in the same cycle, fetch sees it before the edge
  assign read_data = mem[read_addr];

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
/* fetch stage: pc register, next pc select,
   word address to imem and split of the word into two raw lanes */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import fetch_pkg::*;
#(
  parameter int imem_addr_bits = 8           // imem depth in 64-bit words
)
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,       // level, freezes pc
  input  logic                      take_branch, // one-cycle redirect strobe
  input  logic [xlen-1:0]           target_pc,
  input  logic [2*ilen-1:0]         imem_data,   // two instructions
  output logic [imem_addr_bits-1:0] imem_addr,
  output raw_lane_t                 raw_1,
  output raw_lane_t                 raw_2
);

  logic [xlen-1:0] pc;                       // pc we are fetching now
  logic [xlen-1:0] pc_plus_4;
  logic [xlen-1:0] pc_plus_8;
  logic [xlen-1:0] seq_pc;                   // next pc with no redirect
  logic [xlen-1:0] next_pc;
  logic            pc_en;

  //////////////////////////////
  // next pc

  assign pc_plus_4 = pc + xlen'(4);
  assign pc_plus_8 = pc + xlen'(8);

  // from the odd slot only one instruction is consumed
  assign seq_pc  = pc[2] ? pc_plus_4 : pc_plus_8;
  assign next_pc = take_branch ? target_pc : seq_pc;

  // redirect must win over stall or the branch gets lost
  assign pc_en = take_branch | ~stall;

  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;                              // boot from address 0
    else if (pc_en)
      pc <= next_pc;
  end

  //////////////////////////////
  // memory address and lanes

  // word index, low 3 bits of pc dropped
  assign imem_addr = pc[imem_addr_bits+2:3];

  // lower address sits in the upper half of the word
  always_comb
  begin
    raw_1.valid = ~pc[2];                    // upper slot skipped on odd pc
    raw_1.npc   = pc_plus_4;
    raw_1.ir    = imem_data[2*ilen-1:ilen];

    raw_2.valid = 1'b1;                      // second slot always fetched
    raw_2.npc   = seq_pc;                    // word base + 8 either way
    raw_2.ir    = imem_data[ilen-1:0];
  end

endmodule

`default_nettype wire

// File: hdl/predecode.sv
/* predecode of both fetch lanes
   branch detect, branch target and destination register */
`timescale 1ns/1ps
`default_nettype none

module predecode import fetch_pkg::*;
(
  input  raw_lane_t  raw_1,
  input  raw_lane_t  raw_2,
  output fetch_pkt_t pkt
);

  //////////////////////////////
  // helpers

  // inclusive opcode range check
  function automatic logic op_in
  (
    input logic [5:0] op,
    input logic [5:0] lo,
    input logic [5:0] hi
  );
    return (op >= lo) && (op <= hi);
  endfunction

  // disp counts instructions, scale by 4 and sign extend
  function automatic logic [xlen-1:0] disp_offset(input logic [20:0] disp);
    return {{(xlen-23){disp[20]}}, disp, 2'b00};
  endfunction

  //////////////////////////////
  // one lane

  function automatic lane_t decode_lane(input raw_lane_t raw);
    lane_t      lane;
    logic [5:0] op;

    op = raw.ir.br.opcode;                   // opcode sits at the same bits in both formats

    // defaults, also what an invalid lane carries
    lane.raw           = raw;
    lane.is_branch     = 1'b0;
    lane.branch_target = '0;
    lane.dest_reg      = zero_reg;           // no destination

    if (raw.valid)
    begin
      if (op_in(op, op_br_lo, op_br_hi))
      begin
        lane.is_branch     = 1'b1;
        lane.branch_target = raw.npc + disp_offset(raw.ir.br.disp); // relative to pc+4
        lane.dest_reg      = raw.ir.br.ra;   // link reg, r31 for plain br
      end
      else if (op_in(op, op_operate_lo, op_operate_hi))
      begin
        lane.dest_reg = raw.ir.opr.rc;
      end
    end

    return lane;
  endfunction

  //////////////////////////////
  // both lanes, program order kept

  always_comb
  begin
    pkt.lane_1 = decode_lane(raw_1);
    pkt.lane_2 = decode_lane(raw_2);
  end

endmodule

`default_nettype wire

// File: hdl/if_id_reg.sv
/* fetch to decode pipeline register
   flush on redirect, hold on stall */
`timescale 1ns/1ps
`default_nettype none

module if_id_reg import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       stall,        // hold current packet
  input  logic       take_branch,  // kill what was fetched this cycle
  input  fetch_pkt_t pkt_in,
  output fetch_pkt_t pkt_out
);

  logic load;                      // new packet enters this edge

  // a redirect still has to move the register to clear it
  assign load = ~stall | take_branch;

  //////////////////////////////
  // register

  always_ff @(posedge clock)
  begin
    // payload, no reset
    if (load)
      pkt_out <= pkt_in;

    // valids are the only control state here
    if (reset || take_branch)
    begin
      pkt_out.lane_1.raw.valid <= 1'b0;
      pkt_out.lane_2.raw.valid <= 1'b0;   // flushed bubble
    end
  end

  // on stall neither branch above fires, so the whole packet holds
  // the packet fetched in the redirect cycle is from the wrong path
  // and is the one dropped by the flush

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
/* fetch front end top
   fetch stage, imem, predecode and if/id register */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*;
#(
  parameter int imem_addr_bits = 8
)
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,
  input  logic                      take_branch,
  input  logic [xlen-1:0]           target_pc,
  input  logic                      load_en,     // program load
  input  logic [imem_addr_bits-1:0] load_addr,
  input  logic [63:0]               load_data,
  output fetch_pkt_t                fetch_out    // to decode
);

  logic [imem_addr_bits-1:0] imem_addr;
  logic [63:0]               imem_data;
  raw_lane_t                 raw_1;
  raw_lane_t                 raw_2;
  fetch_pkt_t                pre_pkt;            // predecoded, not yet registered

  fetch_stage #(.imem_addr_bits(imem_addr_bits)) fetch_stage_inst
  (
    .clock(clock), .reset(reset), .stall(stall), .take_branch(take_branch),
    .target_pc(target_pc), .imem_data(imem_data), .imem_addr(imem_addr),
    .raw_1(raw_1), .raw_2(raw_2)
  );

  imem #(.imem_addr_bits(imem_addr_bits)) imem_inst
  (
    .clock(clock), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .read_addr(imem_addr), .read_data(imem_data)
  );

  predecode predecode_inst (.raw_1(raw_1), .raw_2(raw_2), .pkt(pre_pkt));

  if_id_reg if_id_reg_inst
  (
    .clock(clock), .reset(reset), .stall(stall), .take_branch(take_branch),
    .pkt_in(pre_pkt), .pkt_out(fetch_out)
  );

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
/* testbench for the fetch front end: program model, lfsr,
   per-cycle stimulus table, lane checks and watchdog */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*;
  ;

  localparam int imem_addr_bits = 8;
  localparam int num_words      = 16;        // program length, one load per cycle
  localparam int num_rows       = 24;
  localparam int reset_cycles   = 4;
  localparam int watchdog_ns    = (num_rows + num_words) * 2 * 20;

  typedef struct packed {
    logic            stall;
    logic            redirect;               // take_branch strobe
    logic [xlen-1:0] target;
    logic [xlen-1:0] pc;                     // pc of the packet expected in fetch_out
    logic            v1;
    logic            v2;
  } row_t;

  logic                      clock;
  logic                      reset;
  logic                      stall;
  logic                      take_branch;
  logic [xlen-1:0]           target_pc;
  logic                      load_en;
  logic [imem_addr_bits-1:0] load_addr;
  logic [63:0]               load_data;
  fetch_pkt_t                fetch_out;

  logic [63:0] prog [num_words];             // model copy of imem
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  // stall, redirect, target, expected pc, v1, v2 (one row per cycle)
  row_t rows [num_rows] = '{
    '{1'b0, 1'b0, 64'h00, 64'h00, 1'b1, 1'b1},   // first packet from pc 0
    '{1'b0, 1'b0, 64'h00, 64'h08, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h10, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h18, 1'b1, 1'b1},
    '{1'b0, 1'b1, 64'h54, 64'h00, 1'b0, 1'b0},   // redirect to odd slot, bubble
    '{1'b0, 1'b0, 64'h00, 64'h54, 1'b0, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h58, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h60, 1'b1, 1'b1},
    '{1'b1, 1'b0, 64'h00, 64'h60, 1'b1, 1'b1},   // stall holds
    '{1'b1, 1'b0, 64'h00, 64'h60, 1'b1, 1'b1},
    '{1'b1, 1'b0, 64'h00, 64'h60, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h68, 1'b1, 1'b1},
    '{1'b1, 1'b0, 64'h00, 64'h68, 1'b1, 1'b1},
    '{1'b1, 1'b1, 64'h10, 64'h00, 1'b0, 1'b0},   // redirect under stall
    '{1'b1, 1'b0, 64'h00, 64'h00, 1'b0, 1'b0},   // bubble held
    '{1'b0, 1'b0, 64'h00, 64'h10, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h18, 1'b1, 1'b1},
    '{1'b0, 1'b1, 64'h2c, 64'h00, 1'b0, 1'b0},
    '{1'b0, 1'b0, 64'h00, 64'h2c, 1'b0, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h30, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h38, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h40, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h48, 1'b1, 1'b1},
    '{1'b0, 1'b0, 64'h00, 64'h50, 1'b1, 1'b1}
  };

  fetch_top #(.imem_addr_bits(imem_addr_bits)) fetch_top_inst
  (
    .clock(clock), .reset(reset), .stall(stall), .take_branch(take_branch),
    .target_pc(target_pc), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .fetch_out(fetch_out)
  );

  //////////////////////////////
  // clock and watchdog

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;              // 20 ns period
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired before the stimulus table finished");
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // helpers

  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] encode_branch(input logic [5:0] op, input logic [4:0] ra,
                                                input logic [20:0] disp);
    return {op, ra, disp};
  endfunction

  function automatic logic [31:0] encode_operate(input logic [5:0] op, input logic [4:0] ra,
                                                 input logic [4:0] rb, input logic [4:0] rc);
    return {op, ra, rb, 11'h000, rc};
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // random words, then fixed slots with known encodings
  task automatic build_program();
    logic [63:0] word;
    lfsr_state = 32'h8fda_ff43;
    for (int w = 0; w < num_words; w++)
    begin
      for (int b = 0; b < 64; b++)
      begin
        lfsr_state = lfsr_next(lfsr_state);    // one step per bit
        word       = {word[62:0], lfsr_state[0]};
      end
      prog[w] = word;
    end
    prog[0][63:32]  = encode_branch(6'h34, 5'd26, 21'd5);      // bsr forward
    prog[1][31:0]   = encode_operate(6'h10, 5'd1, 5'd2, 5'd7);
    prog[2][63:32]  = encode_branch(6'h39, 5'd3, -21'sd3);     // backward
    prog[3][31:0]   = encode_operate(6'h11, 5'd4, 5'd5, 5'd12);
    prog[5][31:0]   = encode_branch(6'h30, 5'd31, -21'sd8);    // plain br, no link
    prog[10][63:32] = encode_branch(6'h3d, 5'd1, 21'd100);     // skipped on odd entry
    prog[12][31:0]  = encode_operate(6'h13, 5'd9, 5'd8, 5'd0);
  endtask

  // one lane against the predecode rules applied to the model
  task automatic check_lane(input string tag, input lane_t act, input logic exp_valid,
                            input logic [63:0] exp_npc, input logic [31:0] exp_ir);
    logic [5:0]  op;
    logic [63:0] offset;
    logic        exp_br;
    logic [63:0] exp_tgt;
    logic [4:0]  exp_dest;
    op       = exp_ir[31:26];
    exp_br   = exp_valid && (op[5:4] == 2'b11);          // 0x30..0x3f
    offset   = {{43{exp_ir[20]}}, exp_ir[20:0]};
    exp_tgt  = exp_br ? exp_npc + (offset << 2) : 64'h0;
    exp_dest = 5'd31;
    if (exp_br)
      exp_dest = exp_ir[25:21];
    else if (exp_valid && op[5:2] == 4'b0100)           // 0x10..0x13
      exp_dest = exp_ir[4:0];
    if (exp_valid)
    begin
      check_val({tag, " npc"}, exp_npc, act.raw.npc);
      check_val({tag, " ir"}, 64'(exp_ir), 64'(act.raw.ir));
    end
    check_val({tag, " is_branch"}, 64'(exp_br), 64'(act.is_branch));
    check_val({tag, " target"}, exp_tgt, act.branch_target);
    check_val({tag, " dest"}, 64'(exp_dest), 64'(act.dest_reg));
  endtask

  task automatic check_row(input int r);
    row_t        row;
    logic [63:0] base;
    logic [63:0] word;
    string       tag;
    row  = rows[r];
    base = {row.pc[63:3], 3'b000};
    word = prog[row.pc[6:3]];
    tag  = $sformatf("row %0d", r);
    check_val({tag, " lane_1 valid"}, 64'(row.v1), 64'(fetch_out.lane_1.raw.valid));
    check_val({tag, " lane_2 valid"}, 64'(row.v2), 64'(fetch_out.lane_2.raw.valid));
    if (row.v2)                              // flushed packets carry no payload
    begin
      check_lane({tag, " lane_1"}, fetch_out.lane_1, row.v1, base + 64'd4, word[63:32]);
      check_lane({tag, " lane_2"}, fetch_out.lane_2, 1'b1, base + 64'd8, word[31:0]);
    end
  endtask

  //////////////////////////////
  // main sequence

  initial
  begin
    errors      = 0;
    checks      = 0;
    reset       = 1'b1;
    stall       = 1'b1;                      // keeps pc at 0 while loading
    take_branch = 1'b0;
    target_pc   = '0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    build_program();

    // load runs through reset and on under stall
    for (int i = 0; i < num_words; i++)
    begin
      @(posedge clock);
      #2;
      load_en   = 1'b1;
      load_addr = imem_addr_bits'(i);
      load_data = prog[i];
      if (i == reset_cycles - 1)
      begin
        reset = 1'b0;
        check_val("after reset lane_1 valid", 64'h0, 64'(fetch_out.lane_1.raw.valid));
        check_val("after reset lane_2 valid", 64'h0, 64'(fetch_out.lane_2.raw.valid));
      end
    end
    @(posedge clock);
    #2;
    load_en = 1'b0;

    for (int r = 0; r < num_rows; r++)
    begin
      stall       = rows[r].stall;           // 2 ns after the edge
      take_branch = rows[r].redirect;
      target_pc   = rows[r].target;
      @(posedge clock);
      #1;
      check_row(r);                          // register settled, inputs not yet moved
      #1;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/fetch_pkg.sv
hdl/imem.sv
hdl/fetch_stage.sv
hdl/predecode.sv
hdl/if_id_reg.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

// File: Makefile
# Verilator flow for the fetch front end
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
